// ==== all.f ====
obb_pkg.sv
obb_decode.sv
obb_execute.sv
obb_result.sv
obb_top.sv
tb_obb.sv

// ==== Bender.yml ====
package:
  name: obb

sources:
  - obb_pkg.sv
  - obb_decode.sv
  - obb_execute.sv
  - obb_result.sv
  - obb_top.sv
  - target: test
    files:
      - tb_obb.sv

// ==== tb_obb.sv ====
`timescale 1ns/1ps

module tb_obb import obb_pkg::*; ();

    localparam int timeout_cycles = 3000;       // well above the combined length of all tests.
    localparam int done_latency   = 18;

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          cyc_cnt = 0;
    int          last_ack;
    int          start_ack;
    int          errors;
    int          tests;
    int          failed_tests;
    int unsigned lcg_state;
    int          px [num_points];
    int          py [num_points];
    int          pz [num_points];
    int          ac [3*num_axes];               // x, y, z of axis 0, then axis 1, then axis 2.

    obb_top i_obb_top (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    initial begin
        wait (cyc_cnt == timeout_cycles);
        $display("ERROR: run stopped at the limit of %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    // ##################################################
    // reference model
    // ##################################################
    function automatic int lcg_next(input int lo, input int span);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lo + int'(lcg_state >> 16) % span;
    endfunction

    function automatic int proj_of(input int p, input int a);
        return px[p] * ac[3*a] + py[p] * ac[3*a+1] + pz[p] * ac[3*a+2];
    endfunction

    // rounds toward minus infinity, also for odd negative values.
    function automatic int floor_half(input int v);
        if (v >= 0) begin
            return v / 2;
        end
        return -((1 - v) / 2);
    endfunction

    function automatic box_axis_t model_axis(input int a);
        int        lo;
        int        hi;
        box_axis_t r;
        lo = proj_of(0, a);
        hi = lo;
        for (int i = 1; i < num_points; i++) begin
            if (proj_of(i, a) < lo) begin
                lo = proj_of(i, a);
            end
            if (proj_of(i, a) > hi) begin
                hi = proj_of(i, a);
            end
        end
        r.center = proj_t'(floor_half(hi + lo));
        r.half   = proj_t'(floor_half(hi - lo));
        return r;
    endfunction

    function automatic logic [wb_dat_w-1:0] point_word(input int i);
        return {2'b00, pz[i][coord_w-1:0], py[i][coord_w-1:0], px[i][coord_w-1:0]};
    endfunction

    // ##################################################
    // bus access and compare tasks
    // ##################################################
    task automatic bus_access(input logic we, input logic [wb_adr_w-1:0] adr,
                              input logic [wb_dat_w-1:0] dat,
                              output logic [wb_dat_w-1:0] rdat);
        if (wb_rsp.ack) begin
            $display("ERROR: ack already high before the request to 0x%h", adr);
            errors++;
        end
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(posedge clk);
        #1;
        last_ack = cyc_cnt;
        rdat     = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            $display("ERROR: no ack in the cycle after the request to 0x%h", adr);
            errors++;
        end
        @(posedge clk);
        #2;
        wb_req = '0;
        if (wb_rsp.ack) begin
            $display("ERROR: ack held for more than one cycle at 0x%h", adr);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [wb_dat_w-1:0] dat);
        logic [wb_dat_w-1:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [wb_dat_w-1:0] dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic check_word(input string name, input logic [wb_dat_w-1:0] got,
                              input logic [wb_dat_w-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_box_axis(input string name, input box_axis_t got, input box_axis_t exp);
        if (got.center !== exp.center) begin
            $display("CHECK FAILED %s.center: got 0x%h expected 0x%h", name, got.center,
                     exp.center);
            errors++;
        end
        if (got.half !== exp.half) begin
            $display("CHECK FAILED %s.half: got 0x%h expected 0x%h", name, got.half, exp.half);
            errors++;
        end
    endtask

    task automatic read_box_axis(input int a, output box_axis_t r);
        logic [wb_dat_w-1:0] c;
        logic [wb_dat_w-1:0] h;
        wb_read(wb_adr_w'(adr_result_base + 2*a), c);
        wb_read(wb_adr_w'(adr_result_base + 2*a + 1), h);
        if (c[wb_dat_w-1:proj_w] !== {(wb_dat_w-proj_w){c[proj_w-1]}} ||
            h[wb_dat_w-1:proj_w] !== {(wb_dat_w-proj_w){h[proj_w-1]}}) begin
            $display("ERROR: result words of axis %0d are not sign-extended", a);
            errors++;
        end
        r.center = c[proj_w-1:0];
        r.half   = h[proj_w-1:0];
    endtask

    task automatic check_results(input string tag);
        box_axis_t got;
        for (int a = 0; a < num_axes; a++) begin
            read_box_axis(a, got);
            check_box_axis($sformatf("%s axis%0d", tag, a), got, model_axis(a));
        end
    endtask

    task automatic load_points();
        for (int i = 0; i < num_points; i++) begin
            wb_write(wb_adr_w'(adr_point_base + i), point_word(i));
        end
    endtask

    task automatic load_axes();
        for (int k = 0; k < 3 * num_axes; k++) begin
            wb_write(wb_adr_w'(adr_axis_base + k), ac[k]);
        end
    endtask

    task automatic start_run();
        wb_write(adr_ctrl, 32'h1);
        start_ack = last_ack;
    endtask

    // status reads land on even offsets from the start ack, so one lands on the done cycle.
    task automatic wait_done();
        logic [wb_dat_w-1:0] st;
        int                  polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < 20) begin
            wb_read(adr_status, st);
            polls++;
        end
        if (!st[1]) begin
            $display("ERROR: engine never reported done");
            errors++;
        end else begin
            check_word("status at done", st, 32'h2);
            if (last_ack - start_ack != done_latency) begin
                $display("ERROR: done seen %0d cycles after the start ack instead of %0d",
                         last_ack - start_ack, done_latency);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    // ##################################################
    // directed tests
    // ##################################################
    task automatic test_reset_state();
        int                  err0;
        logic [wb_dat_w-1:0] d;
        err0 = errors;
        wb_read(adr_status, d);
        check_word("status", d, '0);
        for (int i = 0; i < 2 * num_axes; i++) begin
            wb_read(wb_adr_w'(adr_result_base + i), d);
            check_word($sformatf("result word %0d", i), d, '0);
        end
        report_test("reset_state", err0);
    endtask

    task automatic test_same_points();
        int        err0;
        box_axis_t got;
        box_axis_t exp;
        err0 = errors;
        for (int i = 0; i < num_points; i++) begin
            px[i] = -317;
            py[i] = 208;
            pz[i] = 45;
        end
        for (int k = 0; k < 3 * num_axes; k++) begin
            ac[k] = lcg_next(-32768, 65536);
        end
        load_points();
        load_axes();
        start_run();
        wait_done();
        for (int a = 0; a < num_axes; a++) begin
            read_box_axis(a, got);
            exp.center = proj_t'(proj_of(0, a));
            exp.half   = '0;
            check_box_axis($sformatf("same axis%0d", a), got, exp);
        end
        report_test("same_points", err0);
    endtask

    task automatic test_unit_axes();
        int err0;
        err0 = errors;
        for (int i = 0; i < num_points; i++) begin
            px[i] = -3 + i % 5;
            py[i] = -200 + 3 * i;
            pz[i] = 100 + i;
        end
        px[3]  = -7;                            // x spans -7..4, so the center floors to -2.
        px[9]  = 4;
        py[5]  = -300;
        py[12] = -101;
        pz[7]  = 510;
        pz[14] = 5;
        for (int k = 0; k < 3 * num_axes; k++) begin
            ac[k] = (k % 4 == 0) ? 1 : 0;
        end
        load_points();
        load_axes();
        start_run();
        wait_done();
        check_results("unit");
        report_test("unit_axes", err0);
    endtask

    task automatic test_random();
        int err0;
        err0 = errors;
        for (int i = 0; i < num_points; i++) begin
            px[i] = lcg_next(-512, 1024);
            py[i] = lcg_next(-512, 1024);
            pz[i] = lcg_next(-512, 1024);
        end
        for (int k = 0; k < 3 * num_axes; k++) begin
            ac[k] = lcg_next(-32768, 65536);
        end
        load_points();
        load_axes();
        start_run();
        wait_done();
        check_results("random");
        report_test("random", err0);
    endtask

    task automatic test_busy_writes();
        int                  err0;
        logic [wb_dat_w-1:0] d;
        err0 = errors;
        for (int k = 0; k < 3 * num_axes; k++) begin
            ac[k] = lcg_next(-32768, 65536);
        end
        load_axes();
        start_run();
        wb_write(adr_point_base, ~point_word(0));
        wb_write(adr_axis_base, ~ac[0]);
        wait_done();
        check_results("busy");
        wb_read(adr_point_base, d);
        check_word("point 0", d, point_word(0));
        wb_read(adr_axis_base, d);
        check_word("axis0.x", d, ac[0]);
        for (int k = 0; k < 3 * num_axes; k++) begin
            ac[k] = lcg_next(-32768, 65536);
        end
        load_axes();
        start_run();
        wb_read(adr_status, d);
        check_word("status after restart", d, 32'h1);
        wait_done();
        check_results("restart");
        report_test("busy_writes", err0);
    endtask

    task automatic test_unmapped();
        int                  err0;
        logic [wb_dat_w-1:0] d;
        err0 = errors;
        wb_write(6'h30, 32'hffff_ffff);
        for (int adr = 'h1B; adr < 2 ** wb_adr_w; adr++) begin
            if (adr < adr_result_base || adr >= adr_result_base + 2 * num_axes) begin
                wb_read(wb_adr_w'(adr), d);
                check_word($sformatf("adr 0x%h", adr), d, '0);
            end
        end
        report_test("unmapped", err0);
    endtask

    initial begin
        lcg_state    = 79626;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        rst          = 1'b1;
        wb_req       = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_state();
        test_same_points();
        test_unit_axes();
        test_random();
        test_busy_writes();
        test_unmapped();
        $display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== obb_top.sv ====
`timescale 1ns/1ps

module obb_top import obb_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic       start;
    logic [3:0] point_idx;
    point_t     point;
    axes_t      axes;
    extents_t   extents;
    logic       ext_valid;
    box_t       box;
    logic       box_valid;

    obb_decode i_obb_decode (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .start     (start),
        .point_idx (point_idx),
        .point     (point),
        .axes      (axes),
        .box       (box),
        .box_valid (box_valid)
    );

    obb_execute i_obb_execute (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .point_idx (point_idx),
        .point     (point),
        .axes      (axes),
        .extents   (extents),
        .ext_valid (ext_valid)
    );

    obb_result i_obb_result (
        .clk       (clk),
        .rst       (rst),
        .extents   (extents),
        .ext_valid (ext_valid),
        .box       (box),
        .box_valid (box_valid)
    );

endmodule

// ==== obb_result.sv ====
`timescale 1ns/1ps

module obb_result import obb_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  extents_t extents,
    input  logic     ext_valid,
    output box_t     box,
    output logic     box_valid
);

    // one extra bit keeps the sum exact before the shift.
    logic signed [proj_w:0] sum [num_axes];
    logic signed [proj_w:0] dif [num_axes];

    always_comb begin
        for (int a = 0; a < num_axes; a++) begin
            sum[a] = extents[a].max + extents[a].min;
            dif[a] = extents[a].max - extents[a].min;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            box_valid <= 1'b0;
            box       <= '0;
        end else begin
            box_valid <= ext_valid;
            if (ext_valid) begin
                for (int a = 0; a < num_axes; a++) begin
                    box[a].center <= proj_t'(sum[a] >>> 1);     // floors on odd sums.
                    box[a].half   <= proj_t'(dif[a] >>> 1);
                end
            end
        end
    end

    for (genvar a = 0; a < num_axes; a++) begin : g_half_chk
        a_half_pos: assert property (
            @(posedge clk) disable iff (rst) box_valid |-> box[a].half >= 0
        );
    end

endmodule

// ==== obb_execute.sv ====
`timescale 1ns/1ps

module obb_execute import obb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    output logic [3:0] point_idx,
    input  point_t     point,
    input  axes_t      axes,
    output extents_t   extents,
    output logic       ext_valid
);

    logic       run;
    logic [3:0] cnt;
    logic       s1_valid;
    logic       s1_first;
    logic       s1_last;
    proj_t      s1_proj [num_axes];
    extents_t   ext_q;
    extents_t   ext_next;

    function automatic proj_t dot(input point_t p, input axis_t v);
        return $signed(p.x) * $signed(v.x)
             + $signed(p.y) * $signed(v.y)
             + $signed(p.z) * $signed(v.z);
    endfunction

    // ##################################################
    // stage one: point counter and projections
    // ##################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            run      <= 1'b0;
            cnt      <= '0;
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 4'd1;
                if (cnt == num_points - 1) begin
                    run <= 1'b0;
                end
            end
            s1_valid <= run;
            s1_first <= run && cnt == 0;
            s1_last  <= run && cnt == num_points - 1;
        end
    end

    assign point_idx = cnt;

    always_ff @(posedge clk) begin
        for (int a = 0; a < num_axes; a++) begin
            s1_proj[a] <= dot(point, axes[a]);
        end
    end

    // ##################################################
    // stage two: min/max per axis
    // ##################################################
    always_comb begin
        for (int a = 0; a < num_axes; a++) begin
            if (s1_first) begin
                ext_next[a].min = s1_proj[a];           // the first point seeds both ends.
                ext_next[a].max = s1_proj[a];
            end else begin
                ext_next[a] = ext_q[a];
                if (s1_proj[a] < ext_q[a].min) begin
                    ext_next[a].min = s1_proj[a];
                end
                if (s1_proj[a] > ext_q[a].max) begin
                    ext_next[a].max = s1_proj[a];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            ext_q <= ext_next;
        end
    end

    // the last point is folded in on the way out.
    assign extents   = ext_next;
    assign ext_valid = s1_last;

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !run);

endmodule

// ==== obb_decode.sv ====
`timescale 1ns/1ps

module obb_decode import obb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output logic       start,
    input  logic [3:0] point_idx,
    output point_t     point,
    output axes_t      axes,
    input  box_t       box,
    input  logic       box_valid
);

    logic                     ack;
    logic                     busy;
    logic                     done;
    logic                     acc;
    logic                     wr_ok;
    logic [wb_adr_w-1:0]      pt_off;
    logic [wb_adr_w-1:0]      ax_off;
    logic [wb_adr_w-1:0]      res_off;
    logic                     in_pt;
    logic                     in_ax;
    logic                     in_res;
    logic [wb_dat_w-1:0]      rdata;
    point_t                   point_mem [num_points];
    logic signed [axis_w-1:0] axis_mem [3*num_axes];

    // ##################################################
    // bus handshake and address decode
    // ##################################################
    assign acc   = wb_req.cyc && wb_req.stb && !ack;    // a new access is sampled here.
    assign wr_ok = acc && wb_req.we && !busy;           // writes while busy are dropped.

    assign pt_off  = wb_req.adr - adr_point_base;
    assign ax_off  = wb_req.adr - adr_axis_base;
    assign res_off = wb_req.adr - adr_result_base;
    assign in_pt   = pt_off < num_points;
    assign in_ax   = ax_off < 3 * num_axes;
    assign in_res  = res_off < 2 * num_axes;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            for (int i = 0; i < num_points; i++) begin
                point_mem[i] <= '0;
            end
            for (int i = 0; i < 3 * num_axes; i++) begin
                axis_mem[i] <= '0;
            end
        end else begin
            ack   <= acc;
            start <= 1'b0;
            if (wr_ok && in_pt) begin
                point_mem[pt_off[3:0]] <= wb_req.dat[3*coord_w-1:0];
            end
            if (wr_ok && in_ax) begin
                axis_mem[ax_off[3:0]] <= wb_req.dat[axis_w-1:0];
            end
            if (wr_ok && wb_req.adr == adr_ctrl && wb_req.dat[0]) begin
                start <= 1'b1;
                busy  <= 1'b1;
                done  <= 1'b0;                          // a new run hides the old results.
            end else if (box_valid) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // components are stored x, y, z per axis.
    always_comb begin
        for (int a = 0; a < num_axes; a++) begin
            axes[a].x = axis_mem[3*a];
            axes[a].y = axis_mem[3*a+1];
            axes[a].z = axis_mem[3*a+2];
        end
    end

    assign point = point_mem[point_idx];

    // ##################################################
    // read-back
    // ##################################################
    always_comb begin
        rdata = '0;
        if (in_pt) begin
            rdata = wb_dat_w'(point_mem[pt_off[3:0]]);
        end else if (in_ax) begin
            rdata = wb_dat_w'(axis_mem[ax_off[3:0]]);   // sign-extended.
        end else if (wb_req.adr == adr_status) begin
            rdata[0] = busy && !box_valid;              // status turns over with the results.
            rdata[1] = done || box_valid;
        end else if (in_res) begin
            if (res_off[0]) begin
                rdata = wb_dat_w'(box[res_off[2:1]].half);
            end else begin
                rdata = wb_dat_w'(box[res_off[2:1]].center);
            end
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rdata;

    a_ack_req: assert property (
        @(posedge clk) disable iff (rst) ack |-> wb_req.cyc && wb_req.stb
    );
    a_box_in_busy: assert property (@(posedge clk) disable iff (rst) box_valid |-> busy);

endmodule

// ==== obb_pkg.sv ====
package obb_pkg;

    // ##################################################
    // sizes and widths
    // ##################################################
    localparam int num_points = 16;
    localparam int num_axes   = 3;
    localparam int coord_w    = 10;
    localparam int axis_w     = 16;
    localparam int proj_w     = 28;              // three 10x16 products summed.
    localparam int wb_dat_w   = 32;
    localparam int wb_adr_w   = 6;

    // ##################################################
    // word address map
    // ##################################################
    localparam logic [wb_adr_w-1:0] adr_point_base  = 6'h00;
    localparam logic [wb_adr_w-1:0] adr_axis_base   = 6'h10;
    localparam logic [wb_adr_w-1:0] adr_ctrl        = 6'h19;
    localparam logic [wb_adr_w-1:0] adr_status      = 6'h1A;
    localparam logic [wb_adr_w-1:0] adr_result_base = 6'h20;

    // x sits in the low bits, matching the bus word layout.
    typedef struct packed {
        logic signed [coord_w-1:0] z;
        logic signed [coord_w-1:0] y;
        logic signed [coord_w-1:0] x;
    } point_t;

    typedef struct packed {
        logic signed [axis_w-1:0] z;
        logic signed [axis_w-1:0] y;
        logic signed [axis_w-1:0] x;
    } axis_t;

    typedef axis_t [num_axes-1:0] axes_t;

    typedef logic signed [proj_w-1:0] proj_t;

    typedef struct packed {
        proj_t min;
        proj_t max;
    } extent_t;

    typedef extent_t [num_axes-1:0] extents_t;

    typedef struct packed {
        proj_t center;
        proj_t half;
    } box_axis_t;

    typedef box_axis_t [num_axes-1:0] box_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

endpackage
